//--- common/exePkg.sv
//////////////////////////////////////////////////////////////////////
// shared widths, word types and encodings of the lower execute stage
// imported with a wildcard by every module of the stage
//////////////////////////////////////////////////////////////////////
`default_nettype none

package exePkg;

    localparam int WORD_W = 32;
    localparam int GPR_W  = 5;
    localparam int EXC_W  = 5;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [GPR_W-1:0]  gprNum_t;    // zero means no writeback
    typedef logic [EXC_W-1:0]  excCode_t;
    typedef logic [3:0]        byteEn_t;
    typedef logic [1:0]        fwdMode_t;

    // cause codes as cp0 reports them
    localparam excCode_t EXC_ADEL = 5'h04;  // load address error
    localparam excCode_t EXC_ADES = 5'h05;  // store address error
    localparam excCode_t EXC_OV   = 5'h0c;  // signed overflow

    // bit positions inside fwdMode_t
    localparam int FWD_PREMEM = 0;          // result ready at premem
    localparam int FWD_WB     = 1;          // result only at writeback

    //////////////////////////////////////////////////////////////////////
    // operation encodings
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        ADDU = 4'd1,
        SUB  = 4'd2,
        SUBU = 4'd3,
        AND  = 4'd4,
        OR   = 4'd5,
        XOR  = 4'd6,
        NOR  = 4'd7,
        SLT  = 4'd8,
        SLTU = 4'd9,
        SLL  = 4'd10,
        SRL  = 4'd11,
        SRA  = 4'd12,
        LUI  = 4'd13
    } aluOp_t;

    typedef enum logic [2:0] {
        LB  = 3'd0,
        LBU = 3'd1,
        LH  = 3'd2,
        LHU = 3'd3,
        LW  = 3'd4
    } loadMode_t;

    typedef enum logic [1:0] {
        SB = 2'd0,
        SH = 2'd1,
        SW = 2'd2
    } storeMode_t;

    // which computed condition may raise an exception
    typedef enum logic [1:0] {
        NONE = 2'd0,
        OV   = 2'd1,
        MEM  = 2'd2
    } excSel_t;

endpackage

`default_nettype wire

//--- common/exeBusIf.sv
//////////////////////////////////////////////////////////////////////
// registered instruction fields, driven by the stage register and
// read by the forward, alu and load/store stages
//////////////////////////////////////////////////////////////////////
`default_nettype none

interface exeBusIf import exePkg::*; #(
    parameter int NUM_FWD = 3
) ();
    aluOp_t           aluOp;
    word_t            oprand0;
    word_t            oprand1;
    logic             oprand0IsReg;
    logic             oprand1IsReg;
    word_t            readData0;
    word_t            readData1;
    logic [NUM_FWD:0] fwdSel0;      // one-hot, bit 0 is register data
    logic [NUM_FWD:0] fwdSel1;
    logic             memReq;
    logic             memWr;
    loadMode_t        loadMode;
    storeMode_t       storeMode;
    excSel_t          excSel;
    logic             hasException;
    excCode_t         excCode;
    word_t            vAddr;
    gprNum_t          writeNum;

    modport stage (output aluOp, oprand0, oprand1, oprand0IsReg, oprand1IsReg, readData0,
                   readData1, fwdSel0, fwdSel1, memReq, memWr, loadMode, storeMode,
                   excSel, hasException, excCode, vAddr, writeNum);
    modport fwd (input oprand0, oprand1, oprand0IsReg, oprand1IsReg, readData0, readData1,
                 fwdSel0, fwdSel1);
    modport alu (input aluOp);
    modport lsu (input memReq, memWr, loadMode, storeMode, excSel, hasException, excCode, vAddr);
endinterface

`default_nettype wire

//--- alu/aluCore.sv
//////////////////////////////////////////////////////////////////////
// integer alu, arithmetic, logic, compare and shifts
// overflow flags signed ADD and SUB only
//////////////////////////////////////////////////////////////////////
`default_nettype none

module aluCore import exePkg::*; (
    exeBusIf.alu  bus,
    input  word_t src0_i,
    input  word_t src1_i,
    output word_t aluRes_o,
    output logic  overflow_o
);

    localparam int MSB = WORD_W - 1;

    word_t      sum;
    word_t      diff;
    logic [4:0] shamt;
    logic       addOv;
    logic       subOv;

    assign sum   = src0_i + src1_i;
    assign diff  = src0_i - src1_i;
    assign shamt = src0_i[4:0];    // shift amount from operand 0

    // same-sign inputs with a flipped result sign
    assign addOv = (src0_i[MSB] == src1_i[MSB]) && (sum[MSB] != src0_i[MSB]);
    assign subOv = (src0_i[MSB] != src1_i[MSB]) && (diff[MSB] != src0_i[MSB]);

    always_comb begin
        overflow_o = 1'b0;
        case (bus.aluOp)
            ADD: begin
                aluRes_o   = sum;
                overflow_o = addOv;
            end
            ADDU: aluRes_o = sum;
            SUB: begin
                aluRes_o   = diff;
                overflow_o = subOv;
            end
            SUBU: aluRes_o = diff;
            AND:  aluRes_o = src0_i & src1_i;
            OR:   aluRes_o = src0_i | src1_i;
            XOR:  aluRes_o = src0_i ^ src1_i;
            NOR:  aluRes_o = ~(src0_i | src1_i);
            SLT:  aluRes_o = word_t'($signed(src0_i) < $signed(src1_i));
            SLTU: aluRes_o = word_t'(src0_i < src1_i);
            SLL:  aluRes_o = src1_i << shamt;
            SRL:  aluRes_o = src1_i >> shamt;
            SRA:  aluRes_o = word_t'($signed(src1_i) >>> shamt);
            LUI:  aluRes_o = {src1_i[15:0], 16'h0000};
            default: aluRes_o = '0;    // unused encodings
        endcase
    end

endmodule

`default_nettype wire

//--- lsu/lsuPrep.sv
//////////////////////////////////////////////////////////////////////
// load/store preparation: byte enables, store data, alignment check
// also merges alu and address exceptions into one report
//////////////////////////////////////////////////////////////////////
`default_nettype none

module lsuPrep import exePkg::*; (
    exeBusIf.lsu     bus,
    input  word_t    aluRes_i,
    input  wire      overflow_i,
    input  word_t    regData1_i,
    output byteEn_t  memEnable_o,
    output word_t    storeData_o,
    output logic     hasException_o,
    output excCode_t excCode_o,
    output word_t    badVAddr_o
);

    logic [1:0] offset;
    byteEn_t    storeEn;
    logic       halfAccess;
    logic       wordAccess;
    logic       misalign;
    logic       ovExc;
    logic       memExc;

    assign offset = aluRes_i[1:0];    // address is the alu result

    //////////////////////////////////////////////////////////////////////
    // byte enables and store data
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (bus.storeMode)
            SB: begin
                storeEn     = byteEn_t'(4'b0001 << offset);
                storeData_o = {4{regData1_i[7:0]}};
            end
            SH: begin
                // odd offsets fault, no lanes enabled
                case (offset)
                    2'd0:    storeEn = 4'b0011;
                    2'd2:    storeEn = 4'b1100;
                    default: storeEn = 4'b0000;
                endcase
                storeData_o = {2{regData1_i[15:0]}};
            end
            default: begin
                storeEn     = 4'b1111;
                storeData_o = regData1_i;
            end
        endcase
    end

    assign memEnable_o = bus.memWr ? storeEn : 4'b1111;    // loads read the whole word

    //////////////////////////////////////////////////////////////////////
    // alignment and exception merge
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        if (bus.memWr) begin
            halfAccess = (bus.storeMode == SH);
            wordAccess = (bus.storeMode == SW);
        end else begin
            halfAccess = (bus.loadMode == LH) || (bus.loadMode == LHU);
            wordAccess = (bus.loadMode == LW);
        end
    end

    assign misalign = bus.memReq && ((halfAccess && offset[0]) || (wordAccess && offset != 2'd0));
    assign ovExc    = (bus.excSel == OV) && overflow_i;
    assign memExc   = (bus.excSel == MEM) && misalign;

    assign hasException_o = bus.hasException || ovExc || memExc;

    // an earlier exception keeps its own code and address
    always_comb begin
        if (bus.hasException) begin
            excCode_o  = bus.excCode;
            badVAddr_o = bus.vAddr;
        end else begin
            if (ovExc) begin
                excCode_o = EXC_OV;
            end else begin
                excCode_o = bus.memWr ? EXC_ADES : EXC_ADEL;
            end
            badVAddr_o = aluRes_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/exeStageReg.sv
//////////////////////////////////////////////////////////////////////
// stage register with occupancy flag and valid/allow-in flow control
// the held fields live directly in the bus interface
//////////////////////////////////////////////////////////////////////
`default_nettype none

module exeStageReg import exePkg::*; #(
    parameter int NUM_FWD = 3
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              inValid_i,
    input  wire              nextAllowIn_i,
    input  wire              flush_i,
    input  aluOp_t           aluOp_i,
    input  word_t            oprand0_i,
    input  word_t            oprand1_i,
    input  wire              oprand0IsReg_i,
    input  wire              oprand1IsReg_i,
    input  word_t            readData0_i,
    input  word_t            readData1_i,
    input  wire [NUM_FWD:0]  fwdSel0_i,
    input  wire [NUM_FWD:0]  fwdSel1_i,
    input  wire              memReq_i,
    input  wire              memWr_i,
    input  loadMode_t        loadMode_i,
    input  storeMode_t       storeMode_i,
    input  excSel_t          excSel_i,
    input  wire              hasException_i,
    input  excCode_t         excCode_i,
    input  word_t            vAddr_i,
    input  gprNum_t          writeNum_i,
    exeBusIf.stage           bus,
    output logic             valid_o,
    output logic             allowIn_o,
    output fwdMode_t         fwdMode_o,
    output gprNum_t          writeNum_o,
    output logic             memReq_o,
    output logic             memWr_o
);

    logic hasData;
    logic load;
    logic clear;

    assign allowIn_o = !hasData || nextAllowIn_i;
    assign load      = allowIn_o && inValid_i;
    assign clear     = flush_i || (allowIn_o && !inValid_i);  // flush wins over load
    assign valid_o   = hasData;

    always_ff @(posedge clk) begin
        if (!rst || clear) begin
            hasData          <= 1'b0;
            bus.aluOp        <= ADD;
            bus.oprand0      <= '0;
            bus.oprand1      <= '0;
            bus.oprand0IsReg <= 1'b0;
            bus.oprand1IsReg <= 1'b0;
            bus.readData0    <= '0;
            bus.readData1    <= '0;
            bus.fwdSel0      <= '0;
            bus.fwdSel1      <= '0;
            bus.memReq       <= 1'b0;
            bus.memWr        <= 1'b0;
            bus.loadMode     <= LB;
            bus.storeMode    <= SB;
            bus.excSel       <= NONE;
            bus.hasException <= 1'b0;
            bus.excCode      <= '0;
            bus.vAddr        <= '0;
            bus.writeNum     <= '0;
        end else if (load) begin
            hasData          <= 1'b1;
            bus.aluOp        <= aluOp_i;
            bus.oprand0      <= oprand0_i;
            bus.oprand1      <= oprand1_i;
            bus.oprand0IsReg <= oprand0IsReg_i;
            bus.oprand1IsReg <= oprand1IsReg_i;
            bus.readData0    <= readData0_i;
            bus.readData1    <= readData1_i;
            bus.fwdSel0      <= fwdSel0_i;
            bus.fwdSel1      <= fwdSel1_i;
            bus.memReq       <= memReq_i;
            bus.memWr        <= memWr_i;
            bus.loadMode     <= loadMode_i;
            bus.storeMode    <= storeMode_i;
            bus.excSel       <= excSel_i;
            bus.hasException <= hasException_i;
            bus.excCode      <= excCode_i;
            bus.vAddr        <= vAddr_i;
            bus.writeNum     <= writeNum_i;
        end
    end

    // memory results only come back at writeback
    always_comb begin
        fwdMode_o             = '0;
        fwdMode_o[FWD_PREMEM] = 1'b1;
        fwdMode_o[FWD_WB]     = bus.memReq;
    end

    assign writeNum_o = bus.writeNum;
    assign memReq_o   = bus.memReq;
    assign memWr_o    = bus.memWr;

endmodule

`default_nettype wire

//--- verilog/operandForward.sv
//////////////////////////////////////////////////////////////////////
// operand selection from register data, forward buses or immediate
// purely combinational
//////////////////////////////////////////////////////////////////////
`default_nettype none

module operandForward import exePkg::*; #(
    parameter int NUM_FWD = 3
) (
    exeBusIf.fwd  bus,
    input  word_t fwdData_i [NUM_FWD],
    output word_t src0_o,
    output word_t src1_o,
    output word_t regData1_o
);

    word_t regData0;

    // and-or over the one-hot select, bit k takes fwdData_i[k-1]
    function automatic word_t pickWord(input logic [NUM_FWD:0] sel, input word_t regData);
        word_t res;
        res = {WORD_W{sel[0]}} & regData;
        for (int k = 1; k <= NUM_FWD; k++) begin
            res |= {WORD_W{sel[k]}} & fwdData_i[k-1];
        end
        return res;
    endfunction

    always_comb begin
        regData0   = pickWord(bus.fwdSel0, bus.readData0);
        regData1_o = pickWord(bus.fwdSel1, bus.readData1);
    end

    // immediates bypass the forward network
    assign src0_o = bus.oprand0IsReg ? regData0 : bus.oprand0;
    assign src1_o = bus.oprand1IsReg ? regData1_o : bus.oprand1;

endmodule

`default_nettype wire

//--- verilog/exeDown.sv
//////////////////////////////////////////////////////////////////////
// lower execute stage top: one register stage, then operand forward,
// alu and load/store preparation, all on plain ports
//////////////////////////////////////////////////////////////////////
`default_nettype none

module exeDown import exePkg::*; #(
    parameter int NUM_FWD = 3
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              inValid_i,
    input  wire              nextAllowIn_i,
    input  wire              flush_i,
    // instruction from decode
    input  aluOp_t           aluOp_i,
    input  word_t            oprand0_i,
    input  word_t            oprand1_i,
    input  wire              oprand0IsReg_i,
    input  wire              oprand1IsReg_i,
    input  word_t            readData0_i,
    input  word_t            readData1_i,
    input  wire [NUM_FWD:0]  fwdSel0_i,
    input  wire [NUM_FWD:0]  fwdSel1_i,
    input  wire              memReq_i,
    input  wire              memWr_i,
    input  loadMode_t        loadMode_i,
    input  storeMode_t       storeMode_i,
    input  excSel_t          excSel_i,
    input  wire              hasException_i,
    input  excCode_t         excCode_i,
    input  word_t            vAddr_i,
    input  gprNum_t          writeNum_i,
    input  word_t            fwdData_i [NUM_FWD],   // premem, mem, writeback
    // results
    output logic             valid_o,
    output logic             allowIn_o,
    output fwdMode_t         fwdMode_o,
    output gprNum_t          writeNum_o,
    output word_t            aluRes_o,
    output logic             memReq_o,
    output logic             memWr_o,
    output byteEn_t          memEnable_o,
    output word_t            storeData_o,
    output logic             hasException_o,
    output excCode_t         excCode_o,
    output word_t            badVAddr_o
);

    word_t src0;
    word_t src1;
    word_t regData1;    // forwarded rt, used as store data
    logic  overflow;

    exeBusIf #(.NUM_FWD(NUM_FWD)) bus ();

    exeStageReg #(.NUM_FWD(NUM_FWD)) u_stageReg (
        .clk            (clk),
        .rst            (rst),
        .inValid_i      (inValid_i),
        .nextAllowIn_i  (nextAllowIn_i),
        .flush_i        (flush_i),
        .aluOp_i        (aluOp_i),
        .oprand0_i      (oprand0_i),
        .oprand1_i      (oprand1_i),
        .oprand0IsReg_i (oprand0IsReg_i),
        .oprand1IsReg_i (oprand1IsReg_i),
        .readData0_i    (readData0_i),
        .readData1_i    (readData1_i),
        .fwdSel0_i      (fwdSel0_i),
        .fwdSel1_i      (fwdSel1_i),
        .memReq_i       (memReq_i),
        .memWr_i        (memWr_i),
        .loadMode_i     (loadMode_i),
        .storeMode_i    (storeMode_i),
        .excSel_i       (excSel_i),
        .hasException_i (hasException_i),
        .excCode_i      (excCode_i),
        .vAddr_i        (vAddr_i),
        .writeNum_i     (writeNum_i),
        .bus            (bus.stage),
        .valid_o        (valid_o),
        .allowIn_o      (allowIn_o),
        .fwdMode_o      (fwdMode_o),
        .writeNum_o     (writeNum_o),
        .memReq_o       (memReq_o),
        .memWr_o        (memWr_o)
    );

    operandForward #(.NUM_FWD(NUM_FWD)) u_forward (
        .bus        (bus.fwd),
        .fwdData_i  (fwdData_i),
        .src0_o     (src0),
        .src1_o     (src1),
        .regData1_o (regData1)
    );

    aluCore u_alu (
        .bus        (bus.alu),
        .src0_i     (src0),
        .src1_i     (src1),
        .aluRes_o   (aluRes_o),
        .overflow_o (overflow)
    );

    lsuPrep u_lsu (
        .bus            (bus.lsu),
        .aluRes_i       (aluRes_o),
        .overflow_i     (overflow),
        .regData1_i     (regData1),
        .memEnable_o    (memEnable_o),
        .storeData_o    (storeData_o),
        .hasException_o (hasException_o),
        .excCode_o      (excCode_o),
        .badVAddr_o     (badVAddr_o)
    );

endmodule

`default_nettype wire

//--- tests/exeDown_chk.sv
//////////////////////////////////////////////////////////////////////
// concurrent assertions on the execute stage flow control and byte
// enables, bound into every exeDown instance
//////////////////////////////////////////////////////////////////////
`default_nettype none

module exeDown_chk import exePkg::*; (
    input wire     clk,
    input wire     rst,
    input wire     flush_i,
    input wire     nextAllowIn_i,
    input wire     valid_o,
    input wire     memReq_o,
    input wire     memWr_o,
    input byteEn_t memEnable_o,
    input word_t   aluRes_o,
    input word_t   storeData_o,
    input gprNum_t writeNum_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;    // assertion failures so far

    // stage comes up empty
    emptyAfterClear: assert property (@(posedge clk) (!rst || flush_i) |=> !valid_o)
        else begin
            $error("valid_o high the cycle after reset or flush");
            failCount++;
        end

    loadFullWord: assert property (@(posedge clk) disable iff (!rst)
        (valid_o && memReq_o && !memWr_o) |-> memEnable_o == 4'b1111)
        else begin
            $error("load without all byte enables");
            failCount++;
        end

    // held word must not move under back-pressure
    holdStable: assert property (@(posedge clk) disable iff (!rst)
        (valid_o && !nextAllowIn_i && !flush_i) |=> (valid_o && $stable(aluRes_o)
            && $stable(memEnable_o) && $stable(storeData_o) && $stable(writeNum_o)))
        else begin
            $error("output changed while stalled");
            failCount++;
        end

endmodule

bind exeDown exeDown_chk u_chk (.*);

`default_nettype wire

//--- tests/tb_exeDown.sv
//////////////////////////////////////////////////////////////////////
// testbench for the lower execute stage: plays a table of
// instructions through the stage with random back-pressure, flushes
// and forwarded operands, and checks every result against the table
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_exeDown import exePkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    NUM_FWD     = 3;
    localparam int    NUM_ENTRIES = 21;
    localparam int    CYCLE_LIMIT = NUM_ENTRIES * 8 + 40;
    localparam word_t RD0         = 'h00000100;    // register file data
    localparam word_t RD1         = 'h000002a5;

    typedef struct {
        aluOp_t     op;
        word_t      a;
        word_t      b;
        logic [1:0] isReg;     // {oprand1, oprand0}
        logic [3:0] sel0;
        logic [3:0] sel1;
        logic [1:0] mem;       // {memReq, memWr}
        storeMode_t st;
        loadMode_t  ld;
        excSel_t    es;
        logic       inExc;
        excCode_t   inCode;
        word_t      vAddr;
        int         stall;     // nonzero means random back-pressure
        logic       flush;
        word_t      res;
        byteEn_t    en;
        word_t      sd;
        logic       exc;
        excCode_t   code;
        word_t      bad;
    } entry_t;

    entry_t   tbl [NUM_ENTRIES];
    entry_t   cur;
    word_t    fwdData [NUM_FWD];    // premem, mem, writeback
    logic     clk;
    logic     rst;
    logic     inValid;
    logic     nextAllowIn;
    logic     flush;
    gprNum_t  wNum;
    logic     valid;
    logic     allowIn;
    fwdMode_t fwdMode;
    gprNum_t  writeNum;
    word_t    aluRes;
    logic     memReq;
    logic     memWr;
    byteEn_t  memEnable;
    word_t    storeData;
    logic     hasExc;
    excCode_t excCode;
    word_t    badVAddr;
    integer   seed   = 71869;
    int       errors = 0;
    int       cycles = 0;

    exeDown #(.NUM_FWD(NUM_FWD)) u_dut (
        .clk            (clk),
        .rst            (rst),
        .inValid_i      (inValid),
        .nextAllowIn_i  (nextAllowIn),
        .flush_i        (flush),
        .aluOp_i        (cur.op),
        .oprand0_i      (cur.a),
        .oprand1_i      (cur.b),
        .oprand0IsReg_i (cur.isReg[0]),
        .oprand1IsReg_i (cur.isReg[1]),
        .readData0_i    (RD0),
        .readData1_i    (RD1),
        .fwdSel0_i      (cur.sel0),
        .fwdSel1_i      (cur.sel1),
        .memReq_i       (cur.mem[1]),
        .memWr_i        (cur.mem[0]),
        .loadMode_i     (cur.ld),
        .storeMode_i    (cur.st),
        .excSel_i       (cur.es),
        .hasException_i (cur.inExc),
        .excCode_i      (cur.inCode),
        .vAddr_i        (cur.vAddr),
        .writeNum_i     (wNum),
        .fwdData_i      (fwdData),
        .valid_o        (valid),
        .allowIn_o      (allowIn),
        .fwdMode_o      (fwdMode),
        .writeNum_o     (writeNum),
        .aluRes_o       (aluRes),
        .memReq_o       (memReq),
        .memWr_o        (memWr),
        .memEnable_o    (memEnable),
        .storeData_o    (storeData),
        .hasException_o (hasExc),
        .excCode_o      (excCode),
        .badVAddr_o     (badVAddr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus table, expected values worked out by hand
    //////////////////////////////////////////////////////////////////////
    task automatic fillTable();
        // alu on immediates, overflow only under excSel OV
        tbl[0]  = '{ADD,  'h7fffffff, 'h00000001, 2'b00, 4'h1, 4'h1, 2'b00, SW, LW, OV,
                    '0, '0, 'h0, 0, '0, 'h80000000, 4'hf, 'h0, '1, EXC_OV, 'h80000000};
        tbl[1]  = '{ADDU, 'h7fffffff, 'h00000001, 2'b00, 4'h1, 4'h1, 2'b00, SW, LW, OV,
                    '0, '0, 'h0, 0, '0, 'h80000000, 4'hf, 'h0, '0, '0, 'h0};
        tbl[2]  = '{SUB,  'h80000000, 'h00000001, 2'b00, 4'h1, 4'h1, 2'b00, SW, LW, OV,
                    '0, '0, 'h0, 0, '0, 'h7fffffff, 4'hf, 'h0, '1, EXC_OV, 'h7fffffff};
        tbl[3]  = '{ADD,  'h7fffffff, 'h00000001, 2'b00, 4'h1, 4'h1, 2'b00, SW, LW, NONE,
                    '0, '0, 'h0, 1, '0, 'h80000000, 4'hf, 'h0, '0, '0, 'h0};
        tbl[4]  = '{SRA,  'h00000004, 'h80000000, 2'b00, 4'h1, 4'h1, 2'b00, SW, LW, OV,
                    '0, '0, 'h0, 0, '0, 'hf8000000, 4'hf, 'h0, '0, '0, 'h0};
        // forwarding, each select bit on some operand
        tbl[5]  = '{OR,   'h0, 'h0, 2'b11, 4'h1, 4'h2, 2'b00, SW, LW, NONE,
                    '0, '0, 'h0, 0, '0, 'h000011e0, 4'hf, 'h0, '0, '0, 'h0};
        tbl[6]  = '{OR,   'h0, 'h0, 2'b11, 4'h4, 4'h8, 2'b00, SW, LW, NONE,
                    '0, '0, 'h0, 1, '0, 'h0032c7d8, 4'hf, 'h0, '0, '0, 'h0};
        tbl[7]  = '{OR,   'h0, 'h00000005, 2'b01, 4'h8, 4'h1, 2'b00, SW, LW, NONE,
                    '0, '0, 'h0, 0, '0, 'h0030004d, 4'hf, 'h0, '0, '0, 'h0};
        // stores at every legal offset
        tbl[8]  = '{ADDU, 'h00001000, 'h0, 2'b00, 4'h1, 4'h4, 2'b11, SB, LW, MEM,
                    '0, '0, 'h0, 0, '0, 'h00001000, 4'b0001, 'hd0d0d0d0, '0, '0, 'h0};
        tbl[9]  = '{ADDU, 'h00001000, 'h1, 2'b00, 4'h1, 4'h1, 2'b11, SB, LW, MEM,
                    '0, '0, 'h0, 0, '0, 'h00001001, 4'b0010, 'ha5a5a5a5, '0, '0, 'h0};
        tbl[10] = '{ADDU, 'h00001000, 'h2, 2'b00, 4'h1, 4'h2, 2'b11, SB, LW, MEM,
                    '0, '0, 'h0, 0, '0, 'h00001002, 4'b0100, 'he0e0e0e0, '0, '0, 'h0};
        tbl[11] = '{ADDU, 'h00001000, 'h3, 2'b00, 4'h1, 4'h8, 2'b11, SB, LW, MEM,
                    '0, '0, 'h0, 0, '0, 'h00001003, 4'b1000, 'h48484848, '0, '0, 'h0};
        tbl[12] = '{ADDU, 'h0, 'h0, 2'b01, 4'h2, 4'h4, 2'b11, SH, LW, MEM,
                    '0, '0, 'h0, 0, '0, 'h000010e0, 4'b0011, 'hc7d0c7d0, '0, '0, 'h0};
        tbl[13] = '{ADDU, 'h00002000, 'h2, 2'b00, 4'h1, 4'h1, 2'b11, SH, LW, MEM,
                    '0, '0, 'h0, 1, '0, 'h00002002, 4'b1100, 'h02a502a5, '0, '0, 'h0};
        tbl[14] = '{ADDU, 'h00002000, 'h4, 2'b00, 4'h1, 4'h2, 2'b11, SW, LW, MEM,
                    '0, '0, 'h0, 0, '0, 'h00002004, 4'b1111, 'h000010e0, '0, '0, 'h0};
        // misaligned accesses
        tbl[15] = '{ADDU, 'h00003000, 'h1, 2'b00, 4'h1, 4'h1, 2'b10, SW, LH, MEM,
                    '0, '0, 'h0, 0, '0, 'h00003001, 4'hf, 'h0, '1, EXC_ADEL, 'h00003001};
        tbl[16] = '{ADDU, 'h00003000, 'h2, 2'b00, 4'h1, 4'h1, 2'b10, SW, LW, MEM,
                    '0, '0, 'h0, 0, '0, 'h00003002, 4'hf, 'h0, '1, EXC_ADEL, 'h00003002};
        tbl[17] = '{ADDU, 'h00003000, 'h3, 2'b00, 4'h1, 4'h1, 2'b11, SH, LW, MEM,
                    '0, '0, 'h0, 0, '0, 'h00003003, 4'h0, 'h0, '1, EXC_ADES, 'h00003003};
        tbl[18] = '{ADDU, 'h00003000, 'h1, 2'b00, 4'h1, 4'h1, 2'b11, SW, LW, MEM,
                    '0, '0, 'h0, 0, '0, 'h00003001, 4'h0, 'h0, '1, EXC_ADES, 'h00003001};
        // earlier exception wins over the misaligned address
        tbl[19] = '{ADDU, 'h00003000, 'h1, 2'b00, 4'h1, 4'h1, 2'b10, SW, LW, MEM,
                    '1, 5'h0a, 'hbfc00000, 1, '0, 'h00003001, 4'hf, 'h0, '1, 5'h0a, 'hbfc00000};
        tbl[20] = '{ADD,  'h00000001, 'h1, 2'b00, 4'h1, 4'h1, 2'b00, SW, LW, NONE,
                    '0, '0, 'h0, 0, '1, 'h0, 4'hf, 'h0, '0, '0, 'h0};
    endtask

    task automatic reportMismatch(input string field, input word_t got, input word_t want);
        errors++;
        $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, field, got, want);
    endtask

    task automatic checkResults(input entry_t e);
        fwdMode_t expMode;
        expMode             = '0;
        expMode[FWD_PREMEM] = 1'b1;
        expMode[FWD_WB]     = e.mem[1];    // memory results come at writeback
        if (valid !== 1'b1) reportMismatch("valid_o", word_t'(valid), 'h1);
        if (aluRes !== e.res) reportMismatch("aluRes_o", aluRes, e.res);
        if (fwdMode !== expMode) reportMismatch("fwdMode_o", word_t'(fwdMode), word_t'(expMode));
        if (writeNum !== wNum) reportMismatch("writeNum_o", word_t'(writeNum), word_t'(wNum));
        if (memReq !== e.mem[1]) reportMismatch("memReq_o", word_t'(memReq), word_t'(e.mem[1]));
        if (memWr !== e.mem[0]) reportMismatch("memWr_o", word_t'(memWr), word_t'(e.mem[0]));
        if (hasExc !== e.exc) reportMismatch("hasException_o", word_t'(hasExc), word_t'(e.exc));
        if (e.exc && excCode !== e.code) reportMismatch("excCode_o", word_t'(excCode),
                                                         word_t'(e.code));
        if (e.exc && badVAddr !== e.bad) reportMismatch("badVAddr_o", badVAddr, e.bad);
        if (e.mem[1] && (!e.mem[0] || !e.exc) && memEnable !== e.en) begin
            reportMismatch("memEnable_o", word_t'(memEnable), word_t'(e.en));
        end
        if (e.mem == 2'b11 && !e.exc && storeData !== e.sd) begin
            reportMismatch("storeData_o", storeData, e.sd);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // one table entry: accept, optional stall or flush, check, consume
    //////////////////////////////////////////////////////////////////////
    task automatic runEntry(input int idx);
        int stallN;
        stallN = 0;
        if (tbl[idx].stall != 0) begin
            stallN = ($unsigned($random(seed)) % 3) + 1;
        end
        cur         = tbl[idx];
        wNum        = gprNum_t'(idx + 1);
        inValid     = 1'b1;
        nextAllowIn = (stallN == 0) && !tbl[idx].flush;
        @(posedge clk);
        #1;
        inValid = 1'b0;
        while (!valid) begin    // timeout counter guards this
            @(posedge clk);
            #1;
        end
        if (tbl[idx].flush) begin
            flush = 1'b1;
            @(posedge clk);
            #1;
            flush       = 1'b0;
            nextAllowIn = 1'b1;
            if (valid !== 1'b0) reportMismatch("valid_o after flush", word_t'(valid), '0);
        end else begin
            repeat (stallN) begin
                if (valid !== 1'b1) reportMismatch("valid_o in stall", word_t'(valid), 'h1);
                if (allowIn !== 1'b0) reportMismatch("allowIn_o in stall", word_t'(allowIn), '0);
                if (aluRes !== tbl[idx].res) reportMismatch("held aluRes_o", aluRes, tbl[idx].res);
                @(posedge clk);
                #1;
            end
            nextAllowIn = 1'b1;
            #1;
            checkResults(tbl[idx]);
            @(posedge clk);    // consumed here
            #1;
        end
    endtask

    initial begin
        fillTable();
        fwdData[0]  = 'h000010e0;
        fwdData[1]  = 'h0002c7d0;
        fwdData[2]  = 'h00300048;
        cur         = tbl[0];
        wNum        = '0;
        inValid     = 1'b0;
        nextAllowIn = 1'b1;
        flush       = 1'b0;
        rst         = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            runEntry(i);
        end
        @(posedge clk);    // one more edge for the empty check after the last flush
        #1;
        $display("%0d entries run, %0d check errors, %0d assertion failures",
                 NUM_ENTRIES, errors, u_dut.u_chk.failCount);
        if (errors == 0 && u_dut.u_chk.failCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
common/exePkg.sv
common/exeBusIf.sv
alu/aluCore.sv
lsu/lsuPrep.sv
verilog/exeStageReg.sv
verilog/operandForward.sv
verilog/exeDown.sv
tests/exeDown_chk.sv
tests/tb_exeDown.sv

//--- Bender.yml
package:
  name: exe_down

sources:
  - files:
      - common/exePkg.sv
      - common/exeBusIf.sv
      - alu/aluCore.sv
      - lsu/lsuPrep.sv
      - verilog/exeStageReg.sv
      - verilog/operandForward.sv
      - verilog/exeDown.sv
  - target: test
    files:
      - tests/exeDown_chk.sv
      - tests/tb_exeDown.sv
